// File: dv/dist_stim.txt
# oc img_h img_w k stride | expected act writes (3*act_total) wgt writes (k*k*oc) rows (3*in_h)
# one load per line, run back to back
4 4 4 1 1 48 4 12
8 5 6 2 1 126 32 18
3 4 5 2 2 240 12 24
1 1 1 1 1 3 1 3
16 10 20 1 3 4872 16 84
63 8 8 2 1 243 252 27
127 3 3 1 2 75 127 15
2 16 63 2 2 12096 8 96
5 4 2 2 7 621 20 69
31 12 12 2 2 1728 124 72
10 6 40 1 2 2607 10 33
50 3 4 2 5 612 200 36

// File: src.f
logic/dist_pkg.sv
logic/load_ctrl.sv
logic/act_row_router.sv
logic/weight_row_router.sv
logic/row_mem_distributor.sv
dv/row_mem_distributor_props.sv
dv/tb_row_mem_distributor.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the row memory distributor testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_row_mem_distributor \
    -f src.f \
    --Mdir obj_dir \
    -o tb_row_mem_distributor

./obj_dir/tb_row_mem_distributor

// File: dv/tb_row_mem_distributor.sv
module tb_row_mem_distributor;

    import dist_pkg::*;

    localparam string stim_file      = "dv/dist_stim.txt";
    localparam int    timeout_cycles = 20000;

    logic       clk = 1'b0;
    logic       resetn;
    logic       start;
    layer_cfg_t cfg;
    act_beat_t  act_in;
    wgt_beat_t  wgt_in;
    logic       done;
    act_wr_t    act_wr;
    wgt_wr_t    wgt_wr;

    integer seed;
    int     edge_cnt = 0;

    // current case, from the reference model
    int in_w;
    int k;
    int act_total;
    int wgt_total;
    int act_n;
    int wgt_j;

    // expected writes, with the edge count at which each one shows
    act_wr_t act_q[$];
    int      act_due_q[$];
    wgt_wr_t wgt_q[$];
    int      wgt_due_q[$];

    row_mem_distributor #(
        .NUM_ACT_ROWS (num_act_rows),
        .NUM_WGT_ROWS (num_wgt_rows)
    ) row_mem_distributor_i (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .cfg    (cfg),
        .act_in (act_in),
        .wgt_in (wgt_in),
        .done   (done),
        .act_wr (act_wr),
        .wgt_wr (wgt_wr)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic check_act(input act_wr_t got, input act_wr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at time %0t: act write %0d/%0d/%h, expected %0d/%0d/%h",
                $time, got.data, got.addr, got.strobe, exp.data, exp.addr, exp.strobe));
        end
    endtask

    task automatic check_wgt(input wgt_wr_t got, input wgt_wr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at time %0t: wgt write %0d/%0d/%b, expected %0d/%0d/%b",
                $time, got.data, got.addr, got.strobe, exp.data, exp.addr, exp.strobe));
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL at time %0t: done is %b, expected %b", $time, got, exp));
        end
    endtask

    // ------------------------------
    // stream driving
    // ------------------------------
    task automatic drive_idle();
        act_in.data = '0;
        act_in.addr = '1;
        wgt_in.data = '0;
        wgt_in.addr = '1;
    endtask

    // next element of each stream, or its total once the stream has run out
    task automatic drive_beats();
        act_wr_t     exp_a;
        wgt_wr_t     exp_w;
        logic [31:0] rnd;
        rnd         = $random(seed);
        act_in.data = rnd[7:0];
        wgt_in.data = rnd[15:8];
        rnd         = $random(seed);
        // junk config, only the start edge may look at it
        cfg         = rnd[$bits(layer_cfg_t)-1:0];
        act_in.addr = act_addr_bw'(act_total);
        wgt_in.addr = wgt_addr_bw'(wgt_total);
        if (act_n < 3 * act_total) begin
            act_in.addr                = act_addr_bw'(act_n % act_total);
            exp_a                      = '0;
            exp_a.data                 = act_in.data;
            exp_a.addr                 = row_addr_bw'(act_n % in_w);
            exp_a.strobe[act_n / in_w] = 1'b1;
            act_q.push_back(exp_a);
            act_due_q.push_back(edge_cnt + 2);
            act_n++;
        end
        if (wgt_j < wgt_total) begin
            wgt_in.addr                   = wgt_addr_bw'(wgt_j);
            exp_w                         = '0;
            exp_w.data                    = wgt_in.data;
            exp_w.addr                    = row_addr_bw'(wgt_j % k + k * (wgt_j / (k * k)));
            exp_w.strobe[(wgt_j / k) % k] = 1'b1;
            wgt_q.push_back(exp_w);
            wgt_due_q.push_back(edge_cnt + 2);
            wgt_j++;
        end
    endtask

    task automatic check_writes();
        if (act_q.size() != 0 && act_due_q[0] == edge_cnt) begin
            check_act(act_wr, act_q.pop_front());
            act_due_q.delete(0);
        end else if (act_wr.strobe != '0) begin
            abort_run("an activation write strobe showed up with no element due at this edge");
        end
        if (wgt_q.size() != 0 && wgt_due_q[0] == edge_cnt) begin
            check_wgt(wgt_wr, wgt_q.pop_front());
            wgt_due_q.delete(0);
        end else if (wgt_wr.strobe != '0) begin
            abort_run("a weight write strobe showed up with no element due at this edge");
        end
    endtask

    task automatic run_case(input int oc, img_h, img_w, kk, stride, exp_act, exp_wgt, exp_rows);
        layer_cfg_t cfg_v;
        act_wr_t    quiet_a;
        wgt_wr_t    quiet_w;
        int         in_h;
        int         wait_cnt;
        logic       drained;
        logic       done_seen;
        in_h      = (img_h - 1) * stride + kk;
        in_w      = (img_w - 1) * stride + kk;
        k         = kk;
        act_total = in_h * in_w;
        wgt_total = kk * kk * oc;
        if (3 * act_total != exp_act || wgt_total != exp_wgt || 3 * in_h != exp_rows) begin
            abort_run($sformatf("stim line with oc %0d and k %0d does not fit its geometry",
                oc, kk));
        end
        act_n      = 0;
        wgt_j      = 0;
        cfg_v      = '{oc: 8'(oc), img_h: 6'(img_h), img_w: 6'(img_w), k: 3'(kk),
                       stride: 3'(stride)};
        @(negedge clk);
        start = 1'b1;
        cfg   = cfg_v;
        @(negedge clk);
        start     = 1'b0;
        drained   = 1'b0;
        done_seen = 1'b0;
        wait_cnt  = 0;
        while (!done_seen) begin
            if (wait_cnt >= timeout_cycles) begin
                abort_run("timed out waiting for done at the end of a load");
            end
            drive_beats();
            @(negedge clk);
            wait_cnt++;
            check_writes();
            // done follows one cycle after the last write of both streams
            check_done(done, drained);
            done_seen = done;
            drained   = (act_n == 3 * act_total) && (wgt_j == wgt_total)
                     && (act_q.size() == 0) && (wgt_q.size() == 0);
        end
        drive_idle();
        quiet_a        = act_wr;
        quiet_a.strobe = '0;
        quiet_w        = wgt_wr;
        quiet_w.strobe = '0;
        check_act(act_wr, quiet_a);
        check_wgt(wgt_wr, quiet_w);
        // routers cleared once load has ended
        repeat (2) begin
            @(negedge clk);
            check_done(done, 1'b0);
            check_act(act_wr, '0);
            check_wgt(wgt_wr, '0);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int    fd;
        int    n;
        int    cases;
        int    f[8];
        string line;
        seed   = 43;
        cases  = 0;
        resetn = 1'b0;
        start  = 1'b0;
        cfg    = '0;
        drive_idle();
        repeat (8) @(negedge clk);
        resetn = 1'b1;

        // nothing may move before the first start
        repeat (10) begin
            @(negedge clk);
            check_done(done, 1'b0);
            check_act(act_wr, '0);
            check_wgt(wgt_wr, '0);
        end

        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %d %d %d %d",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (n == 8) begin
                run_case(f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                cases++;
            end
        end
        $fclose(fd);

        if (cases == 0) begin
            abort_run("no test cases were read from the stimulus file");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: dv/row_mem_distributor_props.sv
module row_mem_distributor_props (
    input logic              clk,
    input logic              resetn,
    input logic              done,
    input dist_pkg::act_wr_t act_wr,
    input dist_pkg::wgt_wr_t wgt_wr
);

    // ------------------------------
    // write strobes
    // ------------------------------
    act_strobe_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(act_wr.strobe))
        else $error("act_wr strobe has more than one row set");

    wgt_strobe_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(wgt_wr.strobe))
        else $error("wgt_wr strobe has more than one row set");

    // ------------------------------
    // done pulse
    // ------------------------------
    done_single_cycle: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else $error("done stayed high for two cycles");

    // load is over, row memories stay untouched
    quiet_after_done: assert property (@(posedge clk) disable iff (!resetn)
        done |=> (act_wr.strobe == '0) && (wgt_wr.strobe == '0))
        else $error("write strobe set in the cycle after done");

endmodule

bind row_mem_distributor row_mem_distributor_props row_mem_distributor_props_i (
    .clk    (clk),
    .resetn (resetn),
    .done   (done),
    .act_wr (act_wr),
    .wgt_wr (wgt_wr)
);

// File: logic/row_mem_distributor.sv
module row_mem_distributor #(
    parameter int NUM_ACT_ROWS = dist_pkg::num_act_rows,
    parameter int NUM_WGT_ROWS = dist_pkg::num_wgt_rows
) (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  dist_pkg::layer_cfg_t cfg,
    input  dist_pkg::act_beat_t  act_in,
    input  dist_pkg::wgt_beat_t  wgt_in,
    output logic                 done,
    output dist_pkg::act_wr_t    act_wr,
    output dist_pkg::wgt_wr_t    wgt_wr
);

    import dist_pkg::*;

    logic        loading;
    layer_geom_t geom;
    logic        act_passes_done;
    logic        wgt_done;

    // ------------------------------
    // config and load sequencing
    // ------------------------------
    load_ctrl load_ctrl_i (
        .clk             (clk),
        .resetn          (resetn),
        .start           (start),
        .cfg             (cfg),
        .act_passes_done (act_passes_done),
        .wgt_done        (wgt_done),
        .loading         (loading),
        .geom            (geom),
        .done            (done)
    );

    // ------------------------------
    // stream routers
    // ------------------------------
    act_row_router #(
        .NUM_ACT_ROWS (NUM_ACT_ROWS)
    ) act_row_router_i (
        .clk             (clk),
        .resetn          (resetn),
        .loading         (loading),
        .geom            (geom),
        .act_in          (act_in),
        .act_wr          (act_wr),
        .act_passes_done (act_passes_done)
    );

    weight_row_router #(
        .NUM_WGT_ROWS (NUM_WGT_ROWS)
    ) weight_row_router_i (
        .clk      (clk),
        .resetn   (resetn),
        .loading  (loading),
        .geom     (geom),
        .wgt_in   (wgt_in),
        .wgt_wr   (wgt_wr),
        .wgt_done (wgt_done)
    );

endmodule

// File: logic/weight_row_router.sv
module weight_row_router #(
    parameter int NUM_WGT_ROWS = dist_pkg::num_wgt_rows
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  loading,
    input  dist_pkg::layer_geom_t geom,
    input  dist_pkg::wgt_beat_t   wgt_in,
    output dist_pkg::wgt_wr_t     wgt_wr,
    output logic                  wgt_done
);

    import dist_pkg::*;

    localparam int krow_bw = $clog2(NUM_WGT_ROWS);

    wgt_beat_t                 beat_q;

    // kernel row and output channel of the current beat
    logic [krow_bw-1:0]        krow;
    logic [row_addr_bw-1:0]    oc_cnt;

    logic [2:0]                col;
    logic                      present;
    logic                      col_end;
    logic                      kernel_end;
    logic [row_addr_bw-1:0]    wr_addr;

    logic signed [data_bw-1:0] data_q;
    logic [row_addr_bw-1:0]    addr_q;
    logic [NUM_WGT_ROWS-1:0]   strobe_q;

    // ------------------------------
    // input register
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            beat_q <= '0;
        end else begin
            beat_q <= wgt_in;
        end
    end

    always_comb begin
        col        = 3'(beat_q.addr % wgt_addr_bw'(geom.k));
        present    = beat_q.addr < geom.wgt_total;
        col_end    = present && (col == geom.k - 3'd1);
        // last element of a k*k block
        kernel_end = col_end && (krow == krow_bw'(geom.k - 3'd1));
        // each channel takes k slots in every row
        wr_addr    = row_addr_bw'(col) + oc_cnt * row_addr_bw'(geom.k);
    end

    // ------------------------------
    // counters and write register
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            krow     <= '0;
            oc_cnt   <= '0;
            data_q   <= '0;
            addr_q   <= '0;
            strobe_q <= '0;
        end else if (!loading) begin
            krow     <= '0;
            oc_cnt   <= '0;
            data_q   <= '0;
            addr_q   <= '0;
            strobe_q <= '0;
        end else begin
            data_q   <= beat_q.data;
            addr_q   <= wr_addr;
            strobe_q <= '0;
            if (present) begin
                strobe_q[krow] <= 1'b1;
            end

            if (col_end) begin
                if (kernel_end) begin
                    krow   <= '0;
                    oc_cnt <= oc_cnt + 1'b1;
                end else begin
                    krow <= krow + 1'b1;
                end
            end
        end
    end

    assign wgt_done = beat_q.addr >= geom.wgt_total;

    always_comb begin
        wgt_wr.data   = data_q;
        wgt_wr.addr   = addr_q;
        wgt_wr.strobe = num_wgt_rows'(strobe_q);
    end

endmodule

// File: logic/act_row_router.sv
module act_row_router #(
    parameter int NUM_ACT_ROWS = dist_pkg::num_act_rows
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  loading,
    input  dist_pkg::layer_geom_t geom,
    input  dist_pkg::act_beat_t   act_in,
    output dist_pkg::act_wr_t     act_wr,
    output logic                  act_passes_done
);

    import dist_pkg::*;

    localparam int row_cnt_bw  = $clog2(NUM_ACT_ROWS);
    localparam int pass_cnt_bw = $clog2(num_ic_pass + 1);

    act_beat_t                 beat_q;

    // row memory that takes the current beat
    logic [row_cnt_bw-1:0]     row_cnt;
    logic [pass_cnt_bw-1:0]    pass_cnt;

    logic [row_addr_bw-1:0]    col;
    logic                      present;
    logic                      row_end;
    logic                      pass_end;
    logic                      all_passes;

    logic signed [data_bw-1:0] data_q;
    logic [row_addr_bw-1:0]    addr_q;
    logic [NUM_ACT_ROWS-1:0]   strobe_q;

    // ------------------------------
    // input register
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            beat_q <= '0;
        end else begin
            beat_q <= act_in;
        end
    end

    // position of the registered beat
    always_comb begin
        col      = row_addr_bw'(beat_q.addr % act_addr_bw'(geom.in_w));
        present  = beat_q.addr < geom.act_total;
        row_end  = present && (col == geom.in_w - 1'b1);
        pass_end = present && (beat_q.addr == geom.act_total - 1'b1);
    end

    assign all_passes = (pass_cnt == pass_cnt_bw'(num_ic_pass));

    // ------------------------------
    // counters and write register
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            row_cnt  <= '0;
            pass_cnt <= '0;
            data_q   <= '0;
            addr_q   <= '0;
            strobe_q <= '0;
        end else if (!loading) begin
            row_cnt  <= '0;
            pass_cnt <= '0;
            data_q   <= '0;
            addr_q   <= '0;
            strobe_q <= '0;
        end else begin
            data_q   <= beat_q.data;
            addr_q   <= col;
            strobe_q <= '0;
            if (present) begin
                strobe_q[row_cnt] <= 1'b1;
            end

            // rows keep counting across passes
            if (row_end) begin
                row_cnt <= row_cnt + 1'b1;
            end

            if (pass_end && !all_passes) begin
                pass_cnt <= pass_cnt + 1'b1;
            end
        end
    end

    // last pass ended and stream now idles at its total
    assign act_passes_done = all_passes && (beat_q.addr >= geom.act_total);

    always_comb begin
        act_wr.data   = data_q;
        act_wr.addr   = addr_q;
        act_wr.strobe = num_act_rows'(strobe_q);
    end

endmodule

// File: logic/load_ctrl.sv
module load_ctrl (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start,
    input  dist_pkg::layer_cfg_t  cfg,
    input  logic                  act_passes_done,
    input  logic                  wgt_done,
    output logic                  loading,
    output dist_pkg::layer_geom_t geom,
    output logic                  done
);

    import dist_pkg::*;

    // holds (63 - 1) * 7 + 7 without overflow
    localparam int side_bw = 10;

    load_state_t        state;
    load_state_t        state_nxt;
    layer_geom_t        geom_nxt;
    logic [side_bw-1:0] in_h;
    logic [side_bw-1:0] in_w;
    logic               take_cfg;

    // ------------------------------
    // geometry from the raw config
    // ------------------------------
    always_comb begin
        // padded input image size
        in_h = (side_bw'(cfg.img_h) - 1'b1) * side_bw'(cfg.stride) + side_bw'(cfg.k);
        in_w = (side_bw'(cfg.img_w) - 1'b1) * side_bw'(cfg.stride) + side_bw'(cfg.k);

        geom_nxt.in_w      = row_addr_bw'(in_w);
        geom_nxt.act_total = act_addr_bw'(in_h) * act_addr_bw'(in_w);
        geom_nxt.wgt_total = wgt_addr_bw'(cfg.k) * wgt_addr_bw'(cfg.k)
                           * wgt_addr_bw'(cfg.oc);
        geom_nxt.k         = cfg.k;
    end

    // config is only looked at on the start edge
    assign take_cfg = (state == idle) && start;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            geom <= '0;
        end else if (take_cfg) begin
            geom <= geom_nxt;
        end
    end

    // ------------------------------
    // load FSM
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (start) begin
                    state_nxt = load;
                end
            end
            load: begin
                // both streams drained
                if (act_passes_done && wgt_done) begin
                    state_nxt = done_st;
                end
            end
            done_st: begin
                state_nxt = idle;
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    assign loading = (state == load);

    // single cycle, done_st always falls back to idle
    assign done = (state == done_st);

endmodule

// File: logic/dist_pkg.sv
package dist_pkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int data_bw = 8;

    // upstream stream addresses
    localparam int act_addr_bw = 13;
    localparam int wgt_addr_bw = 9;

    // address inside one row memory
    localparam int row_addr_bw = 7;

    localparam int num_act_rows = 96;
    localparam int num_wgt_rows = 3;

    // input channel passes per load
    localparam int num_ic_pass = 3;

    // ------------------------------
    // types
    // ------------------------------
    typedef enum logic [1:0] {
        idle    = 2'd0,
        load    = 2'd1,
        done_st = 2'd2
    } load_state_t;

    // layer setup, sampled at start
    typedef struct packed {
        logic [7:0] oc;
        logic [5:0] img_h;
        logic [5:0] img_w;
        logic [2:0] k;
        logic [2:0] stride;
    } layer_cfg_t;

    // derived sizes for one load
    typedef struct packed {
        logic [row_addr_bw-1:0] in_w;
        logic [act_addr_bw-1:0] act_total;
        logic [wgt_addr_bw-1:0] wgt_total;
        logic [2:0]             k;
    } layer_geom_t;

    // one element of a flat stream
    typedef struct packed {
        logic signed [data_bw-1:0] data;
        logic [act_addr_bw-1:0]    addr;
    } act_beat_t;

    typedef struct packed {
        logic signed [data_bw-1:0] data;
        logic [wgt_addr_bw-1:0]    addr;
    } wgt_beat_t;

    // row memory write port
    typedef struct packed {
        logic signed [data_bw-1:0] data;
        logic [row_addr_bw-1:0]    addr;
        logic [num_act_rows-1:0]   strobe;
    } act_wr_t;

    typedef struct packed {
        logic signed [data_bw-1:0] data;
        logic [row_addr_bw-1:0]    addr;
        logic [num_wgt_rows-1:0]   strobe;
    } wgt_wr_t;

endpackage
